// File: list.f
logic/imul_pkg.sv
logic/imul_decode.sv
logic/imul_execute.sv
logic/imul_result.sv
logic/imul_unit.sv
sim/imul_unit_tb.sv

// File: Bender.yml
package:
  name: imul_unit

sources:
  - logic/imul_pkg.sv
  - logic/imul_decode.sv
  - logic/imul_execute.sv
  - logic/imul_result.sv
  - logic/imul_unit.sv
  - target: simulation
    files:
      - sim/imul_unit_tb.sv

// File: sim/imul_unit_tb.sv
`timescale 1ns/1ps

module imul_unit_tb;

  import imul_pkg::*;

  localparam int max_cycles = 20000;  // ~250 requests at 40 cycles with margin.

  logic     clk = 1'b0;
  logic     reset;
  logic     req_valid;
  logic     req_ready;
  mul_req_t req;
  logic     rsp_valid;
  logic     rsp_ready = 1'b0;
  mul_rsp_t rsp;

  logic [1:0] rsp_mode;  // 0 always ready, 1 random, 2 held low.
  mul_rsp_t   exp_q[$];
  mul_rsp_t   expected;
  tag_t       next_tag;
  int         errors;
  int         base_errors;
  int         tests;
  int         req_count;
  int         rsp_count;
  int         cycles;

  imul_unit i_imul_unit (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

  always #2 clk = ~clk;

  // ======================================================================
  // reference model and scoreboard
  // ======================================================================

  function automatic word_t ref_mul(input mul_op_e op, input word_t a, input word_t b);
    logic [63:0] a_ext;
    logic [63:0] b_ext;
    logic [63:0] full;
    a_ext = (op == op_mulh || op == op_mulhsu) ? {{32{a[31]}}, a} : {32'd0, a};
    b_ext = (op == op_mulh) ? {{32{b[31]}}, b} : {32'd0, b};
    full  = a_ext * b_ext;  // low 64 bits are exact for both signs.
    return (op == op_mul) ? full[31:0] : full[63:32];
  endfunction

  always @(posedge clk) begin
    if (!reset) begin
      if (rsp_valid && rsp_ready) begin
        rsp_count++;
        if (exp_q.size() == 0) begin
          $display("response with tag %0h arrived with no request pending", rsp.tag);
          errors++;
        end else begin
          expected = exp_q.pop_front();
          if (rsp.result !== expected.result) begin
            $display("ERR %0t: tag %0h result %08h, expected %08h",
                     $time, rsp.tag, rsp.result, expected.result);
            errors++;
          end
          if (rsp.tag !== expected.tag) begin
            $display("ERR %0t: tag %0h, expected %0h", $time, rsp.tag, expected.tag);
            errors++;
          end
        end
      end
      if (req_valid && req_ready) begin
        req_count++;
        exp_q.push_back(mul_rsp_t'{result: ref_mul(req.op, req.a, req.b), tag: req.tag});
      end
    end
  end

  always @(posedge clk) begin
    case (rsp_mode)
      2'd0:    rsp_ready <= 1'b1;
      2'd1:    rsp_ready <= 1'($urandom % 2);
      default: rsp_ready <= 1'b0;
    endcase
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: no finish within %0d cycles", max_cycles);
      $display("tests failed");
      $finish;
    end
  end

  // ======================================================================
  // stimulus tasks
  // ======================================================================

  task automatic load_req(input mul_op_e op, input word_t a, input word_t b);
    req_valid <= 1'b1;
    req       <= '{op: op, a: a, b: b, tag: next_tag};
    next_tag  = next_tag + 1'b1;
  endtask

  task automatic send_req(input mul_op_e op, input word_t a, input word_t b);
    load_req(op, a, b);
    @(posedge clk);
    while (!req_ready) @(posedge clk);
    req_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    @(posedge clk);
    while (exp_q.size() != 0) @(posedge clk);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %0s: %0s", tests, name, (errors == base_errors) ? "ok" : "failed");
    base_errors = errors;
  endtask

  // ======================================================================
  // test sequence
  // ======================================================================

  initial begin
    int accepted;
    void'($urandom(72));
    reset     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    rsp_mode  = 2'd0;
    next_tag  = '0;
    errors    = 0;
    base_errors = 0;
    tests     = 0;
    req_count = 0;
    rsp_count = 0;
    cycles    = 0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    send_req(op_mul, 32'h0000_0000, 32'h1234_5678);
    send_req(op_mul, 32'h0000_0001, 32'h0000_0001);
    send_req(op_mul, 32'hffff_ffff, 32'hffff_ffff);
    send_req(op_mul, 32'hffff_ffff, 32'h0000_0001);
    send_req(op_mul, 32'h8000_0000, 32'h0000_0002);
    send_req(op_mul, 32'h0001_0000, 32'h0001_0000);
    for (int i = 0; i < 32; i += 5) begin
      send_req(op_mul, 32'h1 << i, 32'h8000_0000 >> i);
    end
    wait_drain();
    end_test("mul directed");

    send_req(op_mulh, 32'h8000_0000, 32'h8000_0000);
    send_req(op_mulh, 32'h8000_0000, 32'hffff_ffff);
    send_req(op_mulh, 32'hffff_ffff, 32'hffff_ffff);
    send_req(op_mulh, 32'hffff_ffff, 32'h0000_0001);
    send_req(op_mulh, 32'hffff_fffe, 32'h7fff_ffff);
    send_req(op_mulh, 32'h7fff_ffff, 32'h7fff_ffff);
    send_req(op_mulh, 32'h1234_5678, 32'hedcb_a988);
    wait_drain();
    end_test("mulh signed");

    send_req(op_mulhu, 32'hffff_ffff, 32'hffff_ffff);
    send_req(op_mulhu, 32'h8000_0000, 32'h8000_0000);
    send_req(op_mulhu, 32'hfedc_ba98, 32'h1234_5678);
    send_req(op_mulhsu, 32'hffff_ffff, 32'hffff_ffff);
    send_req(op_mulhsu, 32'h8000_0000, 32'hffff_ffff);
    send_req(op_mulhsu, 32'hffff_ffff, 32'h0000_0001);
    send_req(op_mulhsu, 32'h7fff_ffff, 32'hffff_ffff);
    wait_drain();
    end_test("mulhu and mulhsu");

    rsp_mode <= 2'd1;
    for (int i = 0; i < 200; i++) begin
      repeat ($urandom % 3) @(posedge clk);  // idle gap with valid low.
      send_req(mul_op_e'($urandom % 4), $urandom,
               ($urandom % 4 == 0) ? word_t'($urandom % 16) : word_t'($urandom));
    end
    wait_drain();
    end_test("random traffic");

    // three entries fill and then the input stalls.
    rsp_mode <= 2'd2;
    repeat (2) @(posedge clk);
    accepted = 0;
    load_req(op_mulhu, $urandom, $urandom);
    for (int i = 0; i < 120; i++) begin
      @(posedge clk);
      if (req_ready) begin
        accepted++;
        load_req(op_mulh, $urandom, $urandom);
      end
    end
    if (req_ready) begin
      $display("req_ready stayed high while responses were held");
      errors++;
    end
    if (accepted != 3) begin
      $display("ERR %0t: %0d requests accepted while held, expected 3", $time, accepted);
      errors++;
    end
    if (!rsp_valid) begin
      $display("no response was waiting at the output while rsp_ready was low");
      errors++;
    end
    rsp_mode <= 2'd0;
    @(posedge clk);
    while (!req_ready) @(posedge clk);
    req_valid <= 1'b0;
    wait_drain();
    end_test("back-pressure");

    if (req_count != rsp_count) begin
      $display("%0d requests accepted but %0d responses returned", req_count, rsp_count);
      errors++;
    end
    $display("tests: %0d, requests: %0d, responses: %0d, errors: %0d",
             tests, req_count, rsp_count, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: logic/imul_unit.sv
`timescale 1ns/1ps

module imul_unit (
  input  logic                clk,
  input  logic                reset,

  input  logic                req_valid,
  output logic                req_ready,
  input  imul_pkg::mul_req_t  req,

  output logic                rsp_valid,
  input  logic                rsp_ready,
  output imul_pkg::mul_rsp_t  rsp
);

  import imul_pkg::*;

  logic      dec_valid;
  logic      dec_ready;
  mul_dec_t  dec;

  logic      prod_valid;
  logic      prod_ready;
  mul_prod_t prod;

  imul_decode i_imul_decode (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec       (dec)
  );

  imul_execute i_imul_execute (
    .clk        (clk),
    .reset      (reset),
    .dec_valid  (dec_valid),
    .dec_ready  (dec_ready),
    .dec        (dec),
    .prod_valid (prod_valid),
    .prod_ready (prod_ready),
    .prod       (prod)
  );

  imul_result i_imul_result (
    .clk        (clk),
    .reset      (reset),
    .prod_valid (prod_valid),
    .prod_ready (prod_ready),
    .prod       (prod),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp        (rsp)
  );

endmodule

// File: logic/imul_result.sv
`timescale 1ns/1ps

module imul_result (
  input  logic                 clk,
  input  logic                 reset,

  input  logic                 prod_valid,
  output logic                 prod_ready,
  input  imul_pkg::mul_prod_t  prod,

  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  output imul_pkg::mul_rsp_t   rsp
);

  import imul_pkg::*;

  dword_t signed_product;
  word_t  result_word;

  // restore the sign, then pick the half.
  always_comb begin
    signed_product = prod.negate ? (~prod.product + 64'd1) : prod.product;
    if (prod.high) begin
      result_word = signed_product[dword_width-1:word_width];
    end else begin
      result_word = signed_product[word_width-1:0];
    end
  end

  // ======================================================================
  // output buffer
  // ======================================================================

  assign prod_ready = !rsp_valid || rsp_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid <= 1'b0;
    end else if (prod_ready) begin
      rsp_valid <= prod_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid && prod_ready) begin
      rsp.result <= result_word;
      rsp.tag    <= prod.tag;  // tag rides along untouched.
    end
  end

endmodule

// File: logic/imul_execute.sv
`timescale 1ns/1ps

module imul_execute (
  input  logic                 clk,
  input  logic                 reset,

  input  logic                 dec_valid,
  output logic                 dec_ready,
  input  imul_pkg::mul_dec_t   dec,

  output logic                 prod_valid,
  input  logic                 prod_ready,
  output imul_pkg::mul_prod_t  prod
);

  import imul_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_busy,
    st_done
  } state_e;

  state_e state;
  state_e state_next;

  dword_t multiplicand;
  word_t  multiplier;
  word_t  multiplier_shift;
  step_t  steps;
  logic   last_step;

  assign dec_ready  = (state == st_idle);
  assign prod_valid = (state == st_done);

  assign multiplier_shift = multiplier >> 1;

  // early finish once no multiplier bits are left.
  assign last_step = (multiplier_shift == '0) ||
                     (steps == step_t'(step_count - 1));

  // ======================================================================
  // control FSM
  // ======================================================================

  always_comb begin
    state_next = state;
    case (state)
      st_idle: if (dec_valid)  state_next = st_busy;
      st_busy: if (last_step)  state_next = st_done;
      st_done: if (prod_ready) state_next = st_idle;
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // ======================================================================
  // shift-and-add datapath
  // ======================================================================

  always_ff @(posedge clk) begin
    if (dec_valid && dec_ready) begin
      multiplicand <= dword_t'(dec.a_mag);
      multiplier   <= dec.b_mag;
      steps        <= '0;
      prod         <= '{product: '0,
                        negate:  dec.negate,
                        high:    dec.high,
                        tag:     dec.tag};
    end else if (state == st_busy) begin
      if (multiplier[0]) begin
        prod.product <= prod.product + multiplicand;
      end
      multiplicand <= multiplicand << 1;
      multiplier   <= multiplier_shift;
      steps        <= steps + 1'b1;
    end
  end

endmodule

// File: logic/imul_decode.sv
`timescale 1ns/1ps

module imul_decode (
  input  logic                clk,
  input  logic                reset,

  input  logic                req_valid,
  output logic                req_ready,
  input  imul_pkg::mul_req_t  req,

  output logic                dec_valid,
  input  logic                dec_ready,
  output imul_pkg::mul_dec_t  dec
);

  import imul_pkg::*;

  logic     a_signed;
  logic     b_signed;
  logic     a_neg;
  logic     b_neg;
  mul_dec_t dec_next;

  // signedness per operation.
  always_comb begin
    a_signed = (req.op == op_mulh) || (req.op == op_mulhsu);
    b_signed = (req.op == op_mulh);
    a_neg    = a_signed && req.a[word_width-1];
    b_neg    = b_signed && req.b[word_width-1];
  end

  always_comb begin
    dec_next.a_mag  = a_neg ? (~req.a + 32'd1) : req.a;
    dec_next.b_mag  = b_neg ? (~req.b + 32'd1) : req.b;
    dec_next.negate = a_neg ^ b_neg;
    dec_next.high   = (req.op != op_mul);
    dec_next.tag    = req.tag;
  end

  // ======================================================================
  // single-entry buffer
  // ======================================================================

  assign req_ready = !dec_valid || dec_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else if (req_ready) begin
      dec_valid <= req_valid;  // refill or drain.
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      dec <= dec_next;
    end
  end

endmodule

// File: logic/imul_pkg.sv
package imul_pkg;

  // ======================================================================
  // widths
  // ======================================================================

  localparam int unsigned word_width  = 32;
  localparam int unsigned dword_width = 2 * word_width;
  localparam int unsigned tag_width   = 4;
  localparam int unsigned step_width  = 6;
  localparam int unsigned step_count  = 32;  // one step per multiplier bit.

  typedef logic [word_width-1:0]  word_t;
  typedef logic [dword_width-1:0] dword_t;
  typedef logic [tag_width-1:0]   tag_t;
  typedef logic [step_width-1:0]  step_t;

  typedef enum logic [1:0] {
    op_mul,     // low word.
    op_mulh,    // signed x signed, high word.
    op_mulhu,   // unsigned x unsigned, high word.
    op_mulhsu   // signed x unsigned, high word.
  } mul_op_e;

  // ======================================================================
  // stage bundles
  // ======================================================================

  typedef struct packed {
    mul_op_e op;
    word_t   a;
    word_t   b;
    tag_t    tag;
  } mul_req_t;

  typedef struct packed {
    word_t a_mag;
    word_t b_mag;
    logic  negate;
    logic  high;
    tag_t  tag;
  } mul_dec_t;

  typedef struct packed {
    dword_t product;  // product of magnitudes.
    logic   negate;
    logic   high;
    tag_t   tag;
  } mul_prod_t;

  typedef struct packed {
    word_t result;
    tag_t  tag;
  } mul_rsp_t;

endpackage
